// File: verilog.f
+incdir+rtl
rtl/tcdm_pkg.sv
rtl/floo_tcdm_pkg.sv
rtl/stream_register.sv
rtl/flit_xbar.sv
rtl/tcdm_chimney.sv
rtl/group_floo_wrapper.sv
bench/tb_group_floo_wrapper.sv

// File: Bender.yml
package:
  name: group_floo_wrapper

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tcdm_pkg.sv
      - rtl/floo_tcdm_pkg.sv
      - rtl/stream_register.sv
      - rtl/flit_xbar.sv
      - rtl/tcdm_chimney.sv
      - rtl/group_floo_wrapper.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tb_group_floo_wrapper.sv

// File: bench/tb_group_floo_wrapper.sv
// Testbench for the remote TCDM interface of one group
// Random traffic on all four paths, checked against the packing rules

`timescale 1ns/1ps

`include "group_noc_settings.svh"

module tb_group_floo_wrapper;

  localparam int N      = `NUM_TILES;
  localparam int N_RAND = 16;
  localparam int N_HOT  = 8;
  localparam int N_BP   = 4;
  localparam int TOTAL  = 4 * N * N_RAND + 2 * N * N_HOT + N * N_BP;
  localparam int LIMIT  = 20 * TOTAL + 200;

  // Scoreboard key is path offset plus target * N plus source
  localparam int K_FREQ = 0;
  localparam int K_SREQ = N * N;
  localparam int K_FRSP = 2 * N * N;
  localparam int K_MRSP = 3 * N * N;

  logic                                   clk_i;
  logic                                   reset_i;
  tcdm_pkg::group_id_t                    group_id_i;
  tcdm_pkg::tcdm_master_req_t    [N-1:0]  master_req_i;
  logic                          [N-1:0]  master_req_valid_i;
  logic                          [N-1:0]  master_req_ready_o;
  tcdm_pkg::tcdm_master_resp_t   [N-1:0]  master_resp_o;
  logic                          [N-1:0]  master_resp_valid_o;
  logic                          [N-1:0]  master_resp_ready_i;
  tcdm_pkg::tcdm_slave_req_t     [N-1:0]  slave_req_o;
  logic                          [N-1:0]  slave_req_valid_o;
  logic                          [N-1:0]  slave_req_ready_i;
  tcdm_pkg::tcdm_slave_resp_t    [N-1:0]  slave_resp_i;
  logic                          [N-1:0]  slave_resp_valid_i;
  logic                          [N-1:0]  slave_resp_ready_o;
  floo_tcdm_pkg::tcdm_req_flit_t [N-1:0]  floo_req_o;
  logic                          [N-1:0]  floo_req_valid_o;
  logic                          [N-1:0]  floo_req_ready_i;
  floo_tcdm_pkg::tcdm_req_flit_t [N-1:0]  floo_req_i;
  logic                          [N-1:0]  floo_req_valid_i;
  logic                          [N-1:0]  floo_req_ready_o;
  floo_tcdm_pkg::tcdm_rsp_flit_t [N-1:0]  floo_rsp_o;
  logic                          [N-1:0]  floo_rsp_valid_o;
  logic                          [N-1:0]  floo_rsp_ready_i;
  floo_tcdm_pkg::tcdm_rsp_flit_t [N-1:0]  floo_rsp_i;
  logic                          [N-1:0]  floo_rsp_valid_i;
  logic                          [N-1:0]  floo_rsp_ready_o;

  integer             seed;
  int                 errors;
  int                 cycle_count;
  bit                 run;
  bit                 bp_hold;
  bit                 dense;
  bit                 hot;
  int                 left [4][N];
  int                 accepted [N];
  int                 base [N];
  logic [3:0][N-1:0]  fired;
  logic [127:0]       exp_q [$];
  int                 key_q [$];

  group_floo_wrapper i_group_floo_wrapper (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [127:0] rand_bits();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // Reference packing rules
  function automatic floo_tcdm_pkg::tcdm_req_flit_t ref_req_flit(
    input tcdm_pkg::tcdm_master_req_t req, input int tile, input tcdm_pkg::group_id_t grp);
    floo_tcdm_pkg::tcdm_req_flit_t f;
    f.payload.amo      = req.wdata.amo;
    f.payload.wen      = req.wen;
    f.payload.be       = req.be;
    f.payload.data     = req.wdata.data;
    f.meta.meta_id     = req.wdata.meta_id;
    f.meta.core_id     = req.wdata.core_id;
    f.meta.src_tile_id = tcdm_pkg::tile_id_t'(tile);
    f.meta.src_group_id = grp;
    f.meta.tgt_group_id = req.tgt_group_id;
    f.meta.tgt_addr    = req.tgt_addr;
    return f;
  endfunction

  function automatic tcdm_pkg::tcdm_slave_req_t ref_slave_req(
    input floo_tcdm_pkg::tcdm_req_flit_t f);
    tcdm_pkg::tcdm_slave_req_t s;
    s.wdata.meta_id  = f.meta.meta_id;
    s.wdata.core_id  = f.meta.core_id;
    s.wdata.amo      = f.payload.amo;
    s.wdata.data     = f.payload.data;
    s.wen            = f.payload.wen;
    s.be             = f.payload.be;
    s.tile_addr      = f.meta.tgt_addr[`TILE_ROW_WIDTH-1:0];
    s.ini_addr       = f.meta.src_tile_id;
    s.src_group_id   = f.meta.src_group_id;
    return s;
  endfunction

  function automatic floo_tcdm_pkg::tcdm_rsp_flit_t ref_rsp_flit(
    input tcdm_pkg::tcdm_slave_resp_t r);
    floo_tcdm_pkg::tcdm_rsp_flit_t f;
    f.payload.amo  = r.rdata.amo;
    f.payload.data = r.rdata.data;
    f.meta.meta_id = r.rdata.meta_id;
    f.meta.core_id = r.rdata.core_id;
    f.meta.tile_id = r.ini_addr;
    f.meta.group_id = r.src_group_id;
    return f;
  endfunction

  function automatic tcdm_pkg::tcdm_master_resp_t ref_master_resp(
    input floo_tcdm_pkg::tcdm_rsp_flit_t f);
    tcdm_pkg::tcdm_master_resp_t m;
    m.rdata.meta_id = f.meta.meta_id;
    m.rdata.core_id = f.meta.core_id;
    m.rdata.amo     = f.payload.amo;
    m.rdata.data    = f.payload.data;
    return m;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got=%h exp=%h", name, got, exp);
    end
  endtask

  task automatic expect_item(input int key, input logic [127:0] value);
    exp_q.push_back(value);
    key_q.push_back(key);
  endtask

  // Oldest entry with the same key keeps per-source order
  task automatic score_item(input int key, input string name, input logic [127:0] got);
    int idx;
    idx = -1;
    for (int k = exp_q.size() - 1; k >= 0; k--) begin
      if (key_q[k] == key) idx = k;
    end
    if (idx < 0) begin
      errors++;
      $display("Unexpected item on %s with nothing sent toward it", name);
    end else begin
      check_value(name, got, exp_q[idx]);
      exp_q.delete(idx);
      key_q.delete(idx);
    end
  endtask

  function automatic bit all_idle();
    bit idle;
    idle = (exp_q.size() == 0) && (master_req_valid_i == '0) && (slave_resp_valid_i == '0) &&
           (floo_req_valid_i == '0) && (floo_rsp_valid_i == '0);
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < N; i++) begin
        if (left[k][i] != 0) idle = 1'b0;
      end
    end
    return idle;
  endfunction

  // Quiet point between a rising and the next falling edge
  task automatic settle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_idle();
    do settle(); while (!all_idle());
  endtask

  always @(negedge clk_i) begin : drive_inputs
    logic [127:0]                  rnd;
    logic [127:0]                  dat;
    floo_tcdm_pkg::tcdm_req_flit_t req_flit;
    floo_tcdm_pkg::tcdm_rsp_flit_t rsp_flit;
    if (run) begin
      rnd = rand_bits();
      for (int i = 0; i < N; i++) begin
        floo_req_ready_i[i]    = rnd[i] & ~bp_hold;
        slave_req_ready_i[i]   = rnd[N + i];
        floo_rsp_ready_i[i]    = rnd[2*N + i];
        master_resp_ready_i[i] = rnd[3*N + i];
        if (!master_req_valid_i[i] || fired[0][i]) begin
          master_req_valid_i[i] = 1'b0;
          if (left[0][i] > 0 && (dense || rnd[4*N + i])) begin
            dat = rand_bits();
            master_req_i[i] = dat[$bits(tcdm_pkg::tcdm_master_req_t)-1:0];
            master_req_valid_i[i] = 1'b1;
            left[0][i]--;
          end
        end
        if (!slave_resp_valid_i[i] || fired[1][i]) begin
          slave_resp_valid_i[i] = 1'b0;
          if (left[1][i] > 0 && rnd[5*N + i]) begin
            dat = rand_bits();
            slave_resp_i[i] = dat[$bits(tcdm_pkg::tcdm_slave_resp_t)-1:0];
            slave_resp_valid_i[i] = 1'b1;
            left[1][i]--;
          end
        end
        // Incoming request flits name their source in src_tile_id
        if (!floo_req_valid_i[i] || fired[2][i]) begin
          floo_req_valid_i[i] = 1'b0;
          if (left[2][i] > 0 && rnd[6*N + i]) begin
            dat = rand_bits();
            req_flit = dat[$bits(floo_tcdm_pkg::tcdm_req_flit_t)-1:0];
            req_flit.meta.src_tile_id = tcdm_pkg::tile_id_t'(i);
            if (hot) req_flit.meta.tgt_addr[`TILE_ROW_WIDTH +: `TILE_ID_WIDTH] = '0;
            floo_req_i[i] = req_flit;
            floo_req_valid_i[i] = 1'b1;
            left[2][i]--;
          end
        end
        // Source tag in the low core ID bits of response flits
        if (!floo_rsp_valid_i[i] || fired[3][i]) begin
          floo_rsp_valid_i[i] = 1'b0;
          if (left[3][i] > 0 && rnd[7*N + i]) begin
            dat = rand_bits();
            rsp_flit = dat[$bits(floo_tcdm_pkg::tcdm_rsp_flit_t)-1:0];
            rsp_flit.meta.core_id[`TILE_ID_WIDTH-1:0] = tcdm_pkg::tile_id_t'(i);
            if (hot) rsp_flit.meta.tile_id = '0;
            floo_rsp_i[i] = rsp_flit;
            floo_rsp_valid_i[i] = 1'b1;
            left[3][i]--;
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin : scoreboard
    int t;
    if (!reset_i) begin
      // Inputs first so zero-cycle paths find their entry
      for (int i = 0; i < N; i++) begin
        fired[0][i] = master_req_valid_i[i] && master_req_ready_o[i];
        fired[1][i] = slave_resp_valid_i[i] && slave_resp_ready_o[i];
        fired[2][i] = floo_req_valid_i[i] && floo_req_ready_o[i];
        fired[3][i] = floo_rsp_valid_i[i] && floo_rsp_ready_o[i];
        if (fired[0][i]) begin
          accepted[i]++;
          expect_item(K_FREQ + N*i, 128'(ref_req_flit(master_req_i[i], i, group_id_i)));
        end
        if (fired[1][i]) expect_item(K_FRSP + N*i, 128'(ref_rsp_flit(slave_resp_i[i])));
        if (fired[2][i]) begin
          t = int'(floo_req_i[i].meta.tgt_addr[`TILE_ROW_WIDTH +: `TILE_ID_WIDTH]);
          expect_item(K_SREQ + N*t + i, 128'(ref_slave_req(floo_req_i[i])));
        end
        if (fired[3][i]) begin
          t = int'(floo_rsp_i[i].meta.tile_id);
          expect_item(K_MRSP + N*t + i, 128'(ref_master_resp(floo_rsp_i[i])));
        end
      end
      for (int i = 0; i < N; i++) begin
        if (floo_req_valid_o[i] && floo_req_ready_i[i])
          score_item(K_FREQ + N*i, $sformatf("floo_req_o[%0d]", i), 128'(floo_req_o[i]));
        if (slave_req_valid_o[i] && slave_req_ready_i[i])
          score_item(K_SREQ + N*i + int'(slave_req_o[i].ini_addr),
                     $sformatf("slave_req_o[%0d]", i), 128'(slave_req_o[i]));
        if (floo_rsp_valid_o[i] && floo_rsp_ready_i[i])
          score_item(K_FRSP + N*i, $sformatf("floo_rsp_o[%0d]", i), 128'(floo_rsp_o[i]));
        if (master_resp_valid_o[i] && master_resp_ready_i[i])
          score_item(K_MRSP + N*i + int'(master_resp_o[i].rdata.core_id[`TILE_ID_WIDTH-1:0]),
                     $sformatf("master_resp_o[%0d]", i), 128'(master_resp_o[i]));
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < LIMIT) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles with traffic still pending", cycle_count);
    $display("Errors: %0d", errors);
    $display("Test failed");
    $finish;
  end

  initial begin : main
    seed = 32'hbadc;
    errors = 0;
    run = 1'b0;
    bp_hold = 1'b0;
    dense = 1'b0;
    hot = 1'b0;
    fired = '0;
    for (int i = 0; i < N; i++) begin
      accepted[i] = 0;
      for (int k = 0; k < 4; k++) left[k][i] = 0;
    end
    reset_i = 1'b1;
    group_id_i = 2'h2;
    master_req_i = '0;
    master_req_valid_i = '0;
    master_resp_ready_i = '0;
    slave_req_ready_i = '0;
    slave_resp_i = '0;
    slave_resp_valid_i = '0;
    floo_req_ready_i = '0;
    floo_req_i = '0;
    floo_req_valid_i = '0;
    floo_rsp_ready_i = '0;
    floo_rsp_i = '0;
    floo_rsp_valid_i = '0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    // Idle after reset
    repeat (4) begin
      settle();
      check_value("floo_req_valid_o", floo_req_valid_o, '0);
      check_value("floo_rsp_valid_o", floo_rsp_valid_o, '0);
      check_value("slave_req_valid_o", slave_req_valid_o, '0);
      check_value("master_resp_valid_o", master_resp_valid_o, '0);
    end

    // Random traffic on every path
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < 4; k++) left[k][i] = N_RAND;
    end
    run = 1'b1;
    wait_idle();

    // All incoming flits aimed at tile 0
    hot = 1'b1;
    for (int i = 0; i < N; i++) begin
      left[2][i] = N_HOT;
      left[3][i] = N_HOT;
    end
    wait_idle();
    hot = 1'b0;

    // NoC holds off requests, two per tile fit in the register
    bp_hold = 1'b1;
    dense = 1'b1;
    for (int i = 0; i < N; i++) begin
      base[i] = accepted[i];
      left[0][i] = N_BP;
    end
    repeat (12) settle();
    for (int i = 0; i < N; i++) begin
      check_value($sformatf("accepted[%0d]", i), accepted[i] - base[i], 2);
    end
    check_value("master_req_ready_o", master_req_ready_o, '0);
    check_value("floo_req_valid_o", floo_req_valid_o, {N{1'b1}});
    bp_hold = 1'b0;
    wait_idle();
    dense = 1'b0;

    repeat (4) settle();
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected items never arrived", exp_q.size());
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: rtl/group_floo_wrapper.sv
// Remote TCDM interface of one group
// Per-tile chimneys toward the NoC, crossbars for flits coming in

`timescale 1ns/1ps

`include "group_noc_settings.svh"

module group_floo_wrapper (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  tcdm_pkg::group_id_t                            group_id_i,
  // Tile master ports
  input  tcdm_pkg::tcdm_master_req_t    [`NUM_TILES-1:0] master_req_i,
  input  logic                          [`NUM_TILES-1:0] master_req_valid_i,
  output logic                          [`NUM_TILES-1:0] master_req_ready_o,
  output tcdm_pkg::tcdm_master_resp_t   [`NUM_TILES-1:0] master_resp_o,
  output logic                          [`NUM_TILES-1:0] master_resp_valid_o,
  input  logic                          [`NUM_TILES-1:0] master_resp_ready_i,
  // Tile slave ports
  output tcdm_pkg::tcdm_slave_req_t     [`NUM_TILES-1:0] slave_req_o,
  output logic                          [`NUM_TILES-1:0] slave_req_valid_o,
  input  logic                          [`NUM_TILES-1:0] slave_req_ready_i,
  input  tcdm_pkg::tcdm_slave_resp_t    [`NUM_TILES-1:0] slave_resp_i,
  input  logic                          [`NUM_TILES-1:0] slave_resp_valid_i,
  output logic                          [`NUM_TILES-1:0] slave_resp_ready_o,
  // NoC
  output floo_tcdm_pkg::tcdm_req_flit_t [`NUM_TILES-1:0] floo_req_o,
  output logic                          [`NUM_TILES-1:0] floo_req_valid_o,
  input  logic                          [`NUM_TILES-1:0] floo_req_ready_i,
  input  floo_tcdm_pkg::tcdm_req_flit_t [`NUM_TILES-1:0] floo_req_i,
  input  logic                          [`NUM_TILES-1:0] floo_req_valid_i,
  output logic                          [`NUM_TILES-1:0] floo_req_ready_o,
  output floo_tcdm_pkg::tcdm_rsp_flit_t [`NUM_TILES-1:0] floo_rsp_o,
  output logic                          [`NUM_TILES-1:0] floo_rsp_valid_o,
  input  logic                          [`NUM_TILES-1:0] floo_rsp_ready_i,
  input  floo_tcdm_pkg::tcdm_rsp_flit_t [`NUM_TILES-1:0] floo_rsp_i,
  input  logic                          [`NUM_TILES-1:0] floo_rsp_valid_i,
  output logic                          [`NUM_TILES-1:0] floo_rsp_ready_o
);

  tcdm_pkg::tile_id_t            [`NUM_TILES-1:0] req_sel;
  tcdm_pkg::tile_id_t            [`NUM_TILES-1:0] rsp_sel;
  floo_tcdm_pkg::tcdm_req_flit_t [`NUM_TILES-1:0] req_xbar_data;
  logic                          [`NUM_TILES-1:0] req_xbar_valid;
  logic                          [`NUM_TILES-1:0] req_xbar_ready;
  floo_tcdm_pkg::tcdm_rsp_flit_t [`NUM_TILES-1:0] rsp_xbar_data;
  logic                          [`NUM_TILES-1:0] rsp_xbar_valid;
  logic                          [`NUM_TILES-1:0] rsp_xbar_ready;

  // Target tile sits right above the tile row bits
  for (genvar i = 0; i < `NUM_TILES; i++) begin : gen_sel
    assign req_sel[i] = floo_req_i[i].meta.tgt_addr[`TILE_ROW_WIDTH +: `TILE_ID_WIDTH];
    assign rsp_sel[i] = floo_rsp_i[i].meta.tile_id;
  end

  flit_xbar #(
    .flit_t  (floo_tcdm_pkg::tcdm_req_flit_t)
  ) i_req_xbar (
    .clk_i   (clk_i           ),
    .reset_i (reset_i         ),
    .data_i  (floo_req_i      ),
    .sel_i   (req_sel         ),
    .valid_i (floo_req_valid_i),
    .ready_o (floo_req_ready_o),
    .data_o  (req_xbar_data   ),
    .valid_o (req_xbar_valid  ),
    .ready_i (req_xbar_ready  )
  );

  flit_xbar #(
    .flit_t  (floo_tcdm_pkg::tcdm_rsp_flit_t)
  ) i_rsp_xbar (
    .clk_i   (clk_i           ),
    .reset_i (reset_i         ),
    .data_i  (floo_rsp_i      ),
    .sel_i   (rsp_sel         ),
    .valid_i (floo_rsp_valid_i),
    .ready_o (floo_rsp_ready_o),
    .data_o  (rsp_xbar_data   ),
    .valid_o (rsp_xbar_valid  ),
    .ready_i (rsp_xbar_ready  )
  );

  for (genvar i = 0; i < `NUM_TILES; i++) begin : gen_chimney
    tcdm_chimney #(
      .TileId              (tcdm_pkg::tile_id_t'(i))
    ) i_tcdm_chimney (
      .clk_i               (clk_i                 ),
      .reset_i             (reset_i               ),
      .group_id_i          (group_id_i            ),
      .master_req_i        (master_req_i[i]       ),
      .master_req_valid_i  (master_req_valid_i[i] ),
      .master_req_ready_o  (master_req_ready_o[i] ),
      .master_resp_o       (master_resp_o[i]      ),
      .master_resp_valid_o (master_resp_valid_o[i]),
      .master_resp_ready_i (master_resp_ready_i[i]),
      .slave_req_o         (slave_req_o[i]        ),
      .slave_req_valid_o   (slave_req_valid_o[i]  ),
      .slave_req_ready_i   (slave_req_ready_i[i]  ),
      .slave_resp_i        (slave_resp_i[i]       ),
      .slave_resp_valid_i  (slave_resp_valid_i[i] ),
      .slave_resp_ready_o  (slave_resp_ready_o[i] ),
      .req_flit_o          (floo_req_o[i]         ),
      .req_flit_valid_o    (floo_req_valid_o[i]   ),
      .req_flit_ready_i    (floo_req_ready_i[i]   ),
      .req_flit_i          (req_xbar_data[i]      ),
      .req_flit_valid_i    (req_xbar_valid[i]     ),
      .req_flit_ready_o    (req_xbar_ready[i]     ),
      .rsp_flit_o          (floo_rsp_o[i]         ),
      .rsp_flit_valid_o    (floo_rsp_valid_o[i]   ),
      .rsp_flit_ready_i    (floo_rsp_ready_i[i]   ),
      .rsp_flit_i          (rsp_xbar_data[i]      ),
      .rsp_flit_valid_i    (rsp_xbar_valid[i]     ),
      .rsp_flit_ready_o    (rsp_xbar_ready[i]     )
    );
  end

endmodule

// File: rtl/tcdm_chimney.sv
// TCDM chimney of one tile
// Packs master requests and slave responses into flits, unpacks incoming flits

`timescale 1ns/1ps

`include "group_noc_settings.svh"

module tcdm_chimney #(
  parameter tcdm_pkg::tile_id_t TileId = '0
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  tcdm_pkg::group_id_t           group_id_i,
  // Master side
  input  tcdm_pkg::tcdm_master_req_t    master_req_i,
  input  logic                          master_req_valid_i,
  output logic                          master_req_ready_o,
  output tcdm_pkg::tcdm_master_resp_t   master_resp_o,
  output logic                          master_resp_valid_o,
  input  logic                          master_resp_ready_i,
  // Slave side
  output tcdm_pkg::tcdm_slave_req_t     slave_req_o,
  output logic                          slave_req_valid_o,
  input  logic                          slave_req_ready_i,
  input  tcdm_pkg::tcdm_slave_resp_t    slave_resp_i,
  input  logic                          slave_resp_valid_i,
  output logic                          slave_resp_ready_o,
  // NoC side
  output floo_tcdm_pkg::tcdm_req_flit_t req_flit_o,
  output logic                          req_flit_valid_o,
  input  logic                          req_flit_ready_i,
  input  floo_tcdm_pkg::tcdm_req_flit_t req_flit_i,
  input  logic                          req_flit_valid_i,
  output logic                          req_flit_ready_o,
  output floo_tcdm_pkg::tcdm_rsp_flit_t rsp_flit_o,
  output logic                          rsp_flit_valid_o,
  input  logic                          rsp_flit_ready_i,
  input  floo_tcdm_pkg::tcdm_rsp_flit_t rsp_flit_i,
  input  logic                          rsp_flit_valid_i,
  output logic                          rsp_flit_ready_o
);

  floo_tcdm_pkg::tcdm_req_flit_t req_flit_d;
  floo_tcdm_pkg::tcdm_rsp_flit_t rsp_flit_d;

  // Outgoing request, stamped with our tile and group
  assign req_flit_d = '{
    payload: '{
      amo:  master_req_i.wdata.amo,
      wen:  master_req_i.wen,
      be:   master_req_i.be,
      data: master_req_i.wdata.data
    },
    meta: '{
      meta_id:      master_req_i.wdata.meta_id,
      core_id:      master_req_i.wdata.core_id,
      src_tile_id:  TileId,
      src_group_id: group_id_i,
      tgt_group_id: master_req_i.tgt_group_id,
      tgt_addr:     master_req_i.tgt_addr
    }
  };

  stream_register #(
    .flit_t  (floo_tcdm_pkg::tcdm_req_flit_t)
  ) i_req_register (
    .clk_i   (clk_i             ),
    .reset_i (reset_i           ),
    .data_i  (req_flit_d        ),
    .valid_i (master_req_valid_i),
    .ready_o (master_req_ready_o),
    .data_o  (req_flit_o        ),
    .valid_o (req_flit_valid_o  ),
    .ready_i (req_flit_ready_i  )
  );

  // Response goes back to the requester
  assign rsp_flit_d = '{
    payload: '{
      amo:  slave_resp_i.rdata.amo,
      data: slave_resp_i.rdata.data
    },
    meta: '{
      meta_id:  slave_resp_i.rdata.meta_id,
      core_id:  slave_resp_i.rdata.core_id,
      tile_id:  slave_resp_i.ini_addr,
      group_id: slave_resp_i.src_group_id
    }
  };

  stream_register #(
    .flit_t  (floo_tcdm_pkg::tcdm_rsp_flit_t)
  ) i_rsp_register (
    .clk_i   (clk_i             ),
    .reset_i (reset_i           ),
    .data_i  (rsp_flit_d        ),
    .valid_i (slave_resp_valid_i),
    .ready_o (slave_resp_ready_o),
    .data_o  (rsp_flit_o        ),
    .valid_o (rsp_flit_valid_o  ),
    .ready_i (rsp_flit_ready_i  )
  );

  // Incoming request, group and tile bits dropped from the address
  assign slave_req_o = '{
    wdata: '{
      meta_id: req_flit_i.meta.meta_id,
      core_id: req_flit_i.meta.core_id,
      amo:     req_flit_i.payload.amo,
      data:    req_flit_i.payload.data
    },
    wen:          req_flit_i.payload.wen,
    be:           req_flit_i.payload.be,
    tile_addr:    req_flit_i.meta.tgt_addr[`TILE_ROW_WIDTH-1:0],
    ini_addr:     req_flit_i.meta.src_tile_id,
    src_group_id: req_flit_i.meta.src_group_id
  };
  assign slave_req_valid_o = req_flit_valid_i;
  assign req_flit_ready_o  = slave_req_ready_i;

  // Incoming response
  assign master_resp_o = '{
    rdata: '{
      meta_id: rsp_flit_i.meta.meta_id,
      core_id: rsp_flit_i.meta.core_id,
      amo:     rsp_flit_i.payload.amo,
      data:    rsp_flit_i.payload.data
    }
  };
  assign master_resp_valid_o = rsp_flit_valid_i;
  assign rsp_flit_ready_o    = master_resp_ready_i;

endmodule

// File: rtl/flit_xbar.sv
// Flit crossbar
// Routes each tile input to the output named by sel_i, round-robin per output

`timescale 1ns/1ps

`include "group_noc_settings.svh"

module flit_xbar #(
  parameter type flit_t = logic
) (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  input  flit_t              [`NUM_TILES-1:0]      data_i,
  input  tcdm_pkg::tile_id_t [`NUM_TILES-1:0]      sel_i,
  input  logic               [`NUM_TILES-1:0]      valid_i,
  output logic               [`NUM_TILES-1:0]      ready_o,
  output flit_t              [`NUM_TILES-1:0]      data_o,
  output logic               [`NUM_TILES-1:0]      valid_o,
  input  logic               [`NUM_TILES-1:0]      ready_i
);

  localparam int unsigned N = `NUM_TILES;

  // req[o][i]: input i wants output o
  logic               [N-1:0][N-1:0] req;
  tcdm_pkg::tile_id_t [N-1:0]        rr_ptr_q;
  logic               [N-1:0]        locked_q;
  tcdm_pkg::tile_id_t [N-1:0]        gnt_idx;
  logic               [N-1:0]        gnt_valid;

  always_comb begin
    for (int unsigned o = 0; o < N; o++) begin
      for (int unsigned i = 0; i < N; i++) begin
        req[o][i] = valid_i[i] && (sel_i[i] == tcdm_pkg::tile_id_t'(o));
      end
    end
  end

  // Arbitration, highest priority at rr_ptr_q
  always_comb begin
    int unsigned idx;
    idx = 0;
    for (int unsigned o = 0; o < N; o++) begin
      gnt_idx[o]   = rr_ptr_q[o];
      gnt_valid[o] = 1'b0;
      if (locked_q[o]) begin
        // Held grant under back-pressure
        gnt_valid[o] = req[o][rr_ptr_q[o]];
      end else begin
        // Walk backwards so the closest to the pointer wins
        for (int k = N - 1; k >= 0; k--) begin
          idx = (int'(rr_ptr_q[o]) + k) % N;
          if (req[o][idx]) begin
            gnt_idx[o]   = tcdm_pkg::tile_id_t'(idx);
            gnt_valid[o] = 1'b1;
          end
        end
      end
    end
  end

  always_comb begin
    for (int unsigned o = 0; o < N; o++) begin
      data_o[o]  = data_i[gnt_idx[o]];
      valid_o[o] = gnt_valid[o];
    end
    for (int unsigned i = 0; i < N; i++) begin
      ready_o[i] = ready_i[sel_i[i]] && gnt_valid[sel_i[i]] &&
                   (gnt_idx[sel_i[i]] == tcdm_pkg::tile_id_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q <= '0;
      locked_q <= '0;
    end else begin
      for (int unsigned o = 0; o < N; o++) begin
        if (valid_o[o] && ready_i[o]) begin
          // Move past the winner
          rr_ptr_q[o] <= tcdm_pkg::tile_id_t'((int'(gnt_idx[o]) + 1) % N);
          locked_q[o] <= 1'b0;
        end else if (valid_o[o]) begin
          rr_ptr_q[o] <= gnt_idx[o];
          locked_q[o] <= 1'b1;
        end
      end
    end
  end

endmodule

// File: rtl/stream_register.sv
// Stream register
// Two-entry valid/ready buffer, registered output, full throughput

`timescale 1ns/1ps

module stream_register #(
  parameter type flit_t = logic
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  flit_t data_i,
  input  logic  valid_i,
  output logic  ready_o,
  output flit_t data_o,
  output logic  valid_o,
  input  logic  ready_i
);

  flit_t      mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // Ready only looks at the fill level, so no path from ready_i
  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop)  rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

// File: rtl/floo_tcdm_pkg.sv
// Flit types on the NoC side
// Request and response flits, each split into payload and routing meta

package floo_tcdm_pkg;

  typedef struct packed {
    tcdm_pkg::amo_t  amo;
    logic            wen;
    tcdm_pkg::strb_t be;
    tcdm_pkg::data_t data;
  } tcdm_req_payload_t;

  // Source IDs come back as the response destination
  typedef struct packed {
    tcdm_pkg::meta_id_t  meta_id;
    tcdm_pkg::core_id_t  core_id;
    tcdm_pkg::tile_id_t  src_tile_id;
    tcdm_pkg::group_id_t src_group_id;
    tcdm_pkg::group_id_t tgt_group_id;
    tcdm_pkg::tgt_addr_t tgt_addr;
  } tcdm_req_meta_t;

  typedef struct packed {
    tcdm_req_payload_t payload;
    tcdm_req_meta_t    meta;
  } tcdm_req_flit_t;

  typedef struct packed {
    tcdm_pkg::amo_t  amo;
    tcdm_pkg::data_t data;
  } tcdm_rsp_payload_t;

  typedef struct packed {
    tcdm_pkg::meta_id_t  meta_id;
    tcdm_pkg::core_id_t  core_id;
    tcdm_pkg::tile_id_t  tile_id;
    tcdm_pkg::group_id_t group_id;
  } tcdm_rsp_meta_t;

  typedef struct packed {
    tcdm_rsp_payload_t payload;
    tcdm_rsp_meta_t    meta;
  } tcdm_rsp_flit_t;

endpackage

// File: rtl/tcdm_pkg.sv
// TCDM types on the tile side
// Master and slave request and response structs of the remote ports

`include "group_noc_settings.svh"

package tcdm_pkg;

  // Index and data vectors
  typedef logic [`TILE_ID_WIDTH-1:0]  tile_id_t;
  typedef logic [`GROUP_ID_WIDTH-1:0] group_id_t;
  typedef logic [`CORE_ID_WIDTH-1:0]  core_id_t;
  typedef logic [`META_ID_WIDTH-1:0]  meta_id_t;
  typedef logic [`DATA_WIDTH-1:0]     data_t;
  typedef logic [`DATA_WIDTH/8-1:0]   strb_t;
  typedef logic [3:0]                 amo_t;

  // Group-wide and tile-local bank rows
  typedef logic [`TGT_ADDR_WIDTH-1:0] tgt_addr_t;
  typedef logic [`TILE_ROW_WIDTH-1:0] tile_addr_t;

  // Data word with its tags
  typedef struct packed {
    meta_id_t meta_id;
    core_id_t core_id;
    amo_t     amo;
    data_t    data;
  } tcdm_payload_t;

  typedef struct packed {
    tcdm_payload_t wdata;
    logic          wen;
    strb_t         be;
    group_id_t     tgt_group_id;
    tgt_addr_t     tgt_addr;
  } tcdm_master_req_t;

  typedef struct packed {
    tcdm_payload_t rdata;
  } tcdm_master_resp_t;

  // Slave side keeps who asked, for the way back
  typedef struct packed {
    tcdm_payload_t wdata;
    logic          wen;
    strb_t         be;
    tile_addr_t    tile_addr;
    tile_id_t      ini_addr;
    group_id_t     src_group_id;
  } tcdm_slave_req_t;

  typedef struct packed {
    tcdm_payload_t rdata;
    tile_id_t      ini_addr;
    group_id_t     src_group_id;
  } tcdm_slave_resp_t;

endpackage

// File: rtl/group_noc_settings.svh
// Group NoC settings
// Widths and counts shared by the remote TCDM interface of one group

`ifndef GROUP_NOC_SETTINGS_SVH
`define GROUP_NOC_SETTINGS_SVH

// Tiles per group and index widths
`define NUM_TILES 4
`define TILE_ID_WIDTH 2
`define GROUP_ID_WIDTH 2
`define CORE_ID_WIDTH 4

// Register-file tag carried with each access
`define META_ID_WIDTH 3

`define DATA_WIDTH 32

// Bank row address across the group, and within one tile
`define TGT_ADDR_WIDTH 16
`define TILE_ROW_WIDTH 8

`endif
